/* hw/mips_control.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_control (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] id_inst,
	input  logic [`MIPS_RA_W-1:0] ex_dreg,
	input  logic                  ex_we,
	input  logic                  ex_is_load,
	input  logic                  branch_taken,
	output logic                  stall,
	output logic [`MIPS_RA_W-1:0] rs_addr,
	output logic [`MIPS_RA_W-1:0] rt_addr,
	output mips_pkg::alu_op_e     alu_op,
	output logic                  use_imm,
	output logic                  imm_signed,
	output mips_pkg::wb_sel_e     wb_sel,
	output mips_pkg::mem_size_e   mem_size,
	output logic                  load_signed,
	output logic                  mem_write,
	output logic [`MIPS_RA_W-1:0] dreg,
	output logic                  reg_we,
	output mips_pkg::npc_sel_e    npc_sel
);
	import mips_pkg::*;

	opcode_e op;
	funct_e  fn;
	logic    rs_use;
	logic    rt_use;
	logic    is_jump;
	logic    is_jr;

	assign op = opcode_e'(id_inst[`MIPS_OP_F]);
	assign fn = funct_e'(id_inst[`MIPS_FUNCT_F]);

	//////////////////////////////
	// decoder
	always_comb begin
		alu_op      = ALU_ADDU;
		use_imm     = 1'b0;
		imm_signed  = 1'b1;
		wb_sel      = WB_ALU;
		mem_size    = MEM_NONE;
		load_signed = 1'b0;
		mem_write   = 1'b0;
		dreg        = id_inst[`MIPS_RT_F]; // immediate forms and loads
		reg_we      = 1'b0;
		rs_use      = 1'b0;
		rt_use      = 1'b0;
		is_jump     = 1'b0;
		is_jr       = 1'b0;
		case (op)
			OP_SPECIAL: begin
				dreg   = id_inst[`MIPS_RD_F];
				rs_use = 1'b1;
				rt_use = 1'b1;
				reg_we = 1'b1;
				case (fn)
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_ADDU: alu_op = ALU_ADDU;
					FN_SUBU: alu_op = ALU_SUBU;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_JR: begin
						is_jr  = 1'b1;
						rt_use = 1'b0;
						reg_we = 1'b0;
					end
					default: begin // unknown function acts as nop
						rs_use = 1'b0;
						rt_use = 1'b0;
						reg_we = 1'b0;
					end
				endcase
			end
			OP_J: is_jump = 1'b1;
			OP_JAL: begin
				is_jump = 1'b1;
				wb_sel  = WB_LINK;
				dreg    = `MIPS_LINK_REG;
				reg_we  = 1'b1;
			end
			OP_BEQ, OP_BNE: begin // compared in decode
				rs_use = 1'b1;
				rt_use = 1'b1;
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				use_imm    = 1'b1;
				rs_use     = 1'b1;
				reg_we     = 1'b1;
				imm_signed = (op == OP_ADDIU) || (op == OP_SLTI); // logical ops zero-extend
				case (op)
					OP_SLTI: alu_op = ALU_SLT;
					OP_ANDI: alu_op = ALU_AND;
					OP_ORI:  alu_op = ALU_OR;
					OP_XORI: alu_op = ALU_XOR;
					OP_LUI:  alu_op = ALU_LUI;
					default: alu_op = ALU_ADDU;
				endcase
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				use_imm     = 1'b1;
				rs_use      = 1'b1;
				reg_we      = 1'b1;
				wb_sel      = WB_LOAD;
				load_signed = (op == OP_LB) || (op == OP_LH);
				if (op == OP_LW)
					mem_size = MEM_WORD;
				else if (op == OP_LB || op == OP_LBU)
					mem_size = MEM_BYTE;
				else
					mem_size = MEM_HALF;
			end
			OP_SB, OP_SH, OP_SW: begin
				use_imm   = 1'b1;
				rs_use    = 1'b1;
				rt_use    = 1'b1; // store data
				mem_write = 1'b1;
				if (op == OP_SW)
					mem_size = MEM_WORD;
				else if (op == OP_SH)
					mem_size = MEM_HALF;
				else
					mem_size = MEM_BYTE;
			end
			default: ; // unknown opcode is a nop
		endcase
	end

	// unused source fields read as r0 and never match a load
	assign rs_addr = rs_use ? id_inst[`MIPS_RS_F] : '0;
	assign rt_addr = rt_use ? id_inst[`MIPS_RT_F] : '0;

	//////////////////////////////
	// load-use hazard
	// the bubble it puts in EX clears it one cycle later
	assign stall = ex_is_load && ex_we && (ex_dreg != '0)
	               && (ex_dreg == rs_addr || ex_dreg == rt_addr);

	always_comb begin
		if (is_jr)
			npc_sel = NPC_JR;
		else if (is_jump)
			npc_sel = NPC_JUMP;
		else if (branch_taken)
			npc_sel = NPC_BRANCH;
		else
			npc_sel = NPC_SEQ;
	end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_core (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] inst_data,
	input  logic [`MIPS_XLEN-1:0] mem_data_in,
	output logic [`MIPS_XLEN-1:0] inst_addr,
	output logic [`MIPS_XLEN-1:0] mem_addr,
	output logic [`MIPS_XLEN-1:0] mem_data,
	output logic [3:0]            mem_we,
	output logic                  mem_rd
);
	import mips_pkg::*;

	//////////////////////////////
	// IF/ID and decode controls
	logic [`MIPS_XLEN-1:0] id_inst;
	logic [`MIPS_XLEN-1:0] id_npc;
	logic                  stall;
	npc_sel_e              npc_sel;
	logic                  branch_taken;
	logic [`MIPS_XLEN-1:0] branch_target;
	logic [`MIPS_XLEN-1:0] jump_target;
	logic [`MIPS_XLEN-1:0] jr_target;
	logic [`MIPS_RA_W-1:0] rs_addr;
	logic [`MIPS_RA_W-1:0] rt_addr;
	alu_op_e               id_alu_op;
	logic                  id_use_imm;
	logic                  id_imm_signed;
	wb_sel_e               id_wb_sel;
	mem_size_e             id_mem_size;
	logic                  id_load_signed;
	logic                  id_mem_write;
	logic [`MIPS_RA_W-1:0] id_dreg;
	logic                  id_reg_we;

	// ID/EX
	logic [`MIPS_XLEN-1:0] ex_a;
	logic [`MIPS_XLEN-1:0] ex_b;
	logic [15:0]           ex_imm;
	logic [4:0]            ex_shamt;
	logic [`MIPS_XLEN-1:0] ex_npc;
	logic [`MIPS_XLEN-1:0] ex_store_data;
	alu_op_e               ex_alu_op;
	logic                  ex_use_imm;
	logic                  ex_imm_signed;
	wb_sel_e               ex_wb_sel;
	mem_size_e             ex_mem_size;
	logic                  ex_load_signed;
	logic                  ex_mem_write;
	logic [`MIPS_RA_W-1:0] ex_wr_reg;
	logic                  ex_reg_we;
	logic [`MIPS_XLEN-1:0] ex_result;
	logic [`MIPS_RA_W-1:0] ex_dreg;
	logic                  ex_we;
	logic                  ex_is_load;

	// EX/MEM and MEM/WB
	logic [`MIPS_XLEN-1:0] mem_alu;
	logic [`MIPS_XLEN-1:0] mem_store_data;
	mem_size_e             mem_size;
	logic                  mem_load_signed;
	logic                  mem_store;
	wb_sel_e               mem_wb_sel;
	logic [`MIPS_XLEN-1:0] mem_npc;
	logic [`MIPS_RA_W-1:0] mem_dreg;
	logic                  mem_reg_we;
	logic [`MIPS_XLEN-1:0] mem_fwd_data;
	logic [`MIPS_XLEN-1:0] wb_data;
	logic [`MIPS_RA_W-1:0] wb_dreg;
	logic                  wb_we;

	mips_fetch i_fetch (.*);

	mips_control i_control (
		.*,
		.alu_op      (id_alu_op),
		.use_imm     (id_use_imm),
		.imm_signed  (id_imm_signed),
		.wb_sel      (id_wb_sel),
		.mem_size    (id_mem_size),
		.load_signed (id_load_signed),
		.mem_write   (id_mem_write),
		.dreg        (id_dreg),
		.reg_we      (id_reg_we)
	);

	mips_decode i_decode (
		.*,
		.alu_op      (id_alu_op),
		.use_imm     (id_use_imm),
		.imm_signed  (id_imm_signed),
		.wb_sel      (id_wb_sel),
		.mem_size    (id_mem_size),
		.load_signed (id_load_signed),
		.mem_write   (id_mem_write),
		.dreg        (id_dreg),
		.reg_we      (id_reg_we),
		.mem_we_reg  (mem_reg_we)
	);

	mips_execute i_execute (
		.*,
		.load_signed (mem_load_signed),
		.mem_write   (mem_store),
		.wb_sel      (mem_wb_sel)
	);

	mips_mem_stage i_mem_stage (
		.*,
		.load_signed (mem_load_signed),
		.mem_write   (mem_store),
		.wb_sel      (mem_wb_sel)
	);

endmodule

/* hw/mips_decode.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_decode (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  stall,
	input  logic [`MIPS_XLEN-1:0] id_inst,
	input  logic [`MIPS_XLEN-1:0] id_npc,
	input  logic [`MIPS_RA_W-1:0] rs_addr,
	input  logic [`MIPS_RA_W-1:0] rt_addr,
	input  mips_pkg::alu_op_e     alu_op,
	input  logic                  use_imm,
	input  logic                  imm_signed,
	input  mips_pkg::wb_sel_e     wb_sel,
	input  mips_pkg::mem_size_e   mem_size,
	input  logic                  load_signed,
	input  logic                  mem_write,
	input  logic [`MIPS_RA_W-1:0] dreg,
	input  logic                  reg_we,
	input  logic [`MIPS_XLEN-1:0] ex_result,
	input  logic [`MIPS_RA_W-1:0] ex_dreg,
	input  logic                  ex_we,
	input  logic                  ex_is_load,
	input  logic [`MIPS_XLEN-1:0] wb_data,
	input  logic [`MIPS_RA_W-1:0] wb_dreg,
	input  logic                  wb_we,
	input  logic [`MIPS_XLEN-1:0] mem_fwd_data,
	input  logic [`MIPS_RA_W-1:0] mem_dreg,
	input  logic                  mem_we_reg,
	output logic                  branch_taken,
	output logic [`MIPS_XLEN-1:0] branch_target,
	output logic [`MIPS_XLEN-1:0] jump_target,
	output logic [`MIPS_XLEN-1:0] jr_target,
	output logic [`MIPS_XLEN-1:0] ex_a,
	output logic [`MIPS_XLEN-1:0] ex_b,
	output logic [15:0]           ex_imm,
	output logic [4:0]            ex_shamt,
	output logic [`MIPS_XLEN-1:0] ex_npc,
	output logic [`MIPS_XLEN-1:0] ex_store_data,
	output mips_pkg::alu_op_e     ex_alu_op,
	output logic                  ex_use_imm,
	output logic                  ex_imm_signed,
	output mips_pkg::wb_sel_e     ex_wb_sel,
	output mips_pkg::mem_size_e   ex_mem_size,
	output logic                  ex_load_signed,
	output logic                  ex_mem_write,
	output logic [`MIPS_RA_W-1:0] ex_wr_reg,
	output logic                  ex_reg_we
);
	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] regs [1:31]; // r0 is not stored
	logic [`MIPS_XLEN-1:0] fwd_a;
	logic [`MIPS_XLEN-1:0] fwd_b;
	opcode_e               op;

	// EX beats MEM beats WB bypass beats the file
	function automatic logic [`MIPS_XLEN-1:0] fwd(input logic [`MIPS_RA_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (ex_we && !ex_is_load && ex_dreg == addr) // load data not there yet
			return ex_result;
		if (mem_we_reg && mem_dreg == addr)
			return mem_fwd_data;
		if (wb_we && wb_dreg == addr)
			return wb_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wb_we && wb_dreg != '0)
			regs[wb_dreg] <= wb_data;
	end

	always_comb begin
		fwd_a = fwd(rs_addr);
		fwd_b = fwd(rt_addr);
	end

	//////////////////////////////
	// branch and jump resolution
	assign op            = opcode_e'(id_inst[`MIPS_OP_F]);
	assign branch_taken  = (op == OP_BEQ && fwd_a == fwd_b) || (op == OP_BNE && fwd_a != fwd_b);
	assign branch_target = id_npc + {{14{id_inst[15]}}, id_inst[`MIPS_IMM_F], 2'b00};
	assign jump_target   = {id_npc[31:28], id_inst[`MIPS_TARGET_F], 2'b00};
	assign jr_target     = fwd_a;

	//////////////////////////////
	// ID/EX
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_a           <= '0;
			ex_b           <= '0;
			ex_imm         <= '0;
			ex_shamt       <= '0;
			ex_npc         <= '0;
			ex_store_data  <= '0;
			ex_alu_op      <= ALU_ADDU;
			ex_use_imm     <= 1'b0;
			ex_imm_signed  <= 1'b0;
			ex_wb_sel      <= WB_ALU;
			ex_mem_size    <= MEM_NONE;
			ex_load_signed <= 1'b0;
			ex_mem_write   <= 1'b0;
			ex_wr_reg      <= '0;
			ex_reg_we      <= 1'b0;
		end else begin
			ex_a           <= fwd_a;
			ex_b           <= fwd_b;
			ex_imm         <= id_inst[`MIPS_IMM_F];
			ex_shamt       <= id_inst[`MIPS_SHAMT_F];
			ex_npc         <= id_npc;
			ex_store_data  <= mem_write ? fwd_b : '0;
			ex_alu_op      <= alu_op;
			ex_use_imm     <= use_imm;
			ex_imm_signed  <= imm_signed;
			ex_wb_sel      <= wb_sel;
			ex_load_signed <= load_signed;
			ex_wr_reg      <= dreg;
			if (stall) begin // bubble
				ex_reg_we    <= 1'b0;
				ex_mem_size  <= MEM_NONE;
				ex_mem_write <= 1'b0;
			end else begin
				ex_reg_we    <= reg_we;
				ex_mem_size  <= mem_size;
				ex_mem_write <= mem_write;
			end
		end
	end

endmodule

/* hw/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath and register-address widths
`define MIPS_XLEN     32
`define MIPS_RA_W     5

`define MIPS_RESET_PC 32'h0000_0000 // first fetch after reset
`define MIPS_LINK_REG 5'd31         // jal destination

//////////////////////////////
// instruction fields, used as part selects
`define MIPS_OP_F     31:26
`define MIPS_RS_F     25:21
`define MIPS_RT_F     20:16
`define MIPS_RD_F     15:11
`define MIPS_SHAMT_F  10:6
`define MIPS_FUNCT_F  5:0
`define MIPS_IMM_F    15:0
`define MIPS_TARGET_F 25:0

`endif

/* hw/mips_execute.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_execute (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] ex_a,
	input  logic [`MIPS_XLEN-1:0] ex_b,
	input  logic [15:0]           ex_imm,
	input  logic [4:0]            ex_shamt,
	input  logic [`MIPS_XLEN-1:0] ex_npc,
	input  logic [`MIPS_XLEN-1:0] ex_store_data,
	input  mips_pkg::alu_op_e     ex_alu_op,
	input  logic                  ex_use_imm,
	input  logic                  ex_imm_signed,
	input  mips_pkg::wb_sel_e     ex_wb_sel,
	input  mips_pkg::mem_size_e   ex_mem_size,
	input  logic                  ex_load_signed,
	input  logic                  ex_mem_write,
	input  logic [`MIPS_RA_W-1:0] ex_wr_reg,
	input  logic                  ex_reg_we,
	output logic [`MIPS_XLEN-1:0] ex_result,
	output logic [`MIPS_RA_W-1:0] ex_dreg,
	output logic                  ex_we,
	output logic                  ex_is_load,
	output logic [`MIPS_XLEN-1:0] mem_alu,
	output logic [`MIPS_XLEN-1:0] mem_store_data,
	output mips_pkg::mem_size_e   mem_size,
	output logic                  load_signed,
	output logic                  mem_write,
	output mips_pkg::wb_sel_e     wb_sel,
	output logic [`MIPS_XLEN-1:0] mem_npc,
	output logic [`MIPS_RA_W-1:0] mem_dreg,
	output logic                  mem_reg_we
);
	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_XLEN-1:0] op_b;
	logic [`MIPS_XLEN-1:0] alu_res;
	logic [`MIPS_XLEN-1:0] link_addr;

	assign imm_ext   = ex_imm_signed ? {{16{ex_imm[15]}}, ex_imm} : {16'b0, ex_imm};
	assign op_b      = ex_use_imm ? imm_ext : ex_b;
	assign link_addr = ex_npc + 32'd4; // returns past the delay slot

	always_comb begin
		case (ex_alu_op)
			ALU_SUBU: alu_res = ex_a - op_b;
			ALU_AND:  alu_res = ex_a & op_b;
			ALU_OR:   alu_res = ex_a | op_b;
			ALU_XOR:  alu_res = ex_a ^ op_b;
			ALU_NOR:  alu_res = ~(ex_a | op_b);
			ALU_SLT:  alu_res = {31'b0, $signed(ex_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'b0, ex_a < op_b};
			ALU_SLL:  alu_res = op_b << ex_shamt; // rt is the shifted operand
			ALU_SRL:  alu_res = op_b >> ex_shamt;
			ALU_LUI:  alu_res = {ex_imm, 16'b0};
			default:  alu_res = ex_a + op_b;
		endcase
	end

	assign ex_result  = (ex_wb_sel == WB_LINK) ? link_addr : alu_res;
	assign ex_dreg    = ex_reg_we ? ex_wr_reg : '0;
	assign ex_we      = ex_reg_we && (ex_wr_reg != '0); // r0 writes are dropped here
	assign ex_is_load = (ex_mem_size != MEM_NONE) && !ex_mem_write;

	//////////////////////////////
	// EX/MEM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_alu        <= '0;
			mem_store_data <= '0;
			mem_size       <= MEM_NONE;
			load_signed    <= 1'b0;
			mem_write      <= 1'b0;
			wb_sel         <= WB_ALU;
			mem_npc        <= '0;
			mem_dreg       <= '0;
			mem_reg_we     <= 1'b0;
		end else begin
			mem_alu        <= ex_result;
			mem_store_data <= ex_store_data;
			mem_size       <= ex_mem_size;
			load_signed    <= ex_load_signed;
			mem_write      <= ex_mem_write;
			wb_sel         <= ex_wb_sel;
			mem_npc        <= link_addr;
			mem_dreg       <= ex_dreg;
			mem_reg_we     <= ex_we;
		end
	end

endmodule

/* hw/mips_fetch.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_fetch (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  stall,
	input  mips_pkg::npc_sel_e    npc_sel,
	input  logic [`MIPS_XLEN-1:0] branch_target,
	input  logic [`MIPS_XLEN-1:0] jump_target,
	input  logic [`MIPS_XLEN-1:0] jr_target,
	input  logic [`MIPS_XLEN-1:0] inst_data,
	output logic [`MIPS_XLEN-1:0] inst_addr,
	output logic [`MIPS_XLEN-1:0] id_inst,
	output logic [`MIPS_XLEN-1:0] id_npc
);
	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] pc_next;

	assign inst_addr = pc;
	assign pc_plus4  = pc + 32'd4;

	// target comes from the instruction in ID, so the slot behind it still runs
	always_comb begin
		case (npc_sel)
			NPC_BRANCH: pc_next = branch_target;
			NPC_JUMP:   pc_next = jump_target;
			NPC_JR:     pc_next = jr_target;
			default:    pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= `MIPS_RESET_PC;
			id_inst <= '0; // all-zero word is sll r0, a nop
			id_npc  <= '0;
		end else if (!stall) begin
			pc      <= pc_next;
			id_inst <= inst_data;
			id_npc  <= pc_plus4;
		end
	end

endmodule

/* hw/mips_mem_stage.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_mem_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] mem_alu,
	input  logic [`MIPS_XLEN-1:0] mem_store_data,
	input  mips_pkg::mem_size_e   mem_size,
	input  logic                  load_signed,
	input  logic                  mem_write,
	input  mips_pkg::wb_sel_e     wb_sel,
	input  logic [`MIPS_XLEN-1:0] mem_npc,
	input  logic [`MIPS_RA_W-1:0] mem_dreg,
	input  logic                  mem_reg_we,
	input  logic [`MIPS_XLEN-1:0] mem_data_in,
	output logic [`MIPS_XLEN-1:0] mem_addr,
	output logic [`MIPS_XLEN-1:0] mem_data,
	output logic [3:0]            mem_we,
	output logic                  mem_rd,
	output logic [`MIPS_XLEN-1:0] mem_fwd_data,
	output logic [`MIPS_XLEN-1:0] wb_data,
	output logic [`MIPS_RA_W-1:0] wb_dreg,
	output logic                  wb_we
);
	import mips_pkg::*;

	logic [1:0]            lane;
	logic [7:0]            ld_byte;
	logic [15:0]           ld_half;
	logic [`MIPS_XLEN-1:0] ld_val;
	logic [`MIPS_XLEN-1:0] wb_val;

	assign lane     = mem_alu[1:0];
	assign mem_addr = {mem_alu[31:2], 2'b00};
	assign mem_rd   = (mem_size != MEM_NONE) && !mem_write;

	//////////////////////////////
	// store steering
	always_comb begin
		mem_we   = 4'b0000;
		mem_data = mem_store_data;
		case (mem_size)
			MEM_BYTE: begin
				mem_we   = 4'b0001 << lane;
				mem_data = {24'b0, mem_store_data[7:0]} << {lane, 3'b000};
			end
			MEM_HALF: begin
				mem_we   = lane[1] ? 4'b1100 : 4'b0011; // lane[0] ignored
				mem_data = {16'b0, mem_store_data[15:0]} << {lane[1], 4'b0000};
			end
			MEM_WORD: mem_we = 4'b1111;
			default:  mem_we = 4'b0000;
		endcase
		if (!mem_write)
			mem_we = 4'b0000; // loads share the size field
	end

	//////////////////////////////
	// load extraction
	assign ld_byte = mem_data_in[{lane, 3'b000} +: 8];
	assign ld_half = mem_data_in[{lane[1], 4'b0000} +: 16];

	always_comb begin
		case (mem_size)
			MEM_BYTE: ld_val = load_signed ? {{24{ld_byte[7]}}, ld_byte} : {24'b0, ld_byte};
			MEM_HALF: ld_val = load_signed ? {{16{ld_half[15]}}, ld_half} : {16'b0, ld_half};
			default:  ld_val = mem_data_in;
		endcase
	end

	always_comb begin
		case (wb_sel)
			WB_LOAD: wb_val = ld_val;
			WB_LINK: wb_val = mem_npc;
			default: wb_val = mem_alu;
		endcase
	end

	assign mem_fwd_data = wb_val; // back to decode

	// MEM/WB
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_data <= '0;
			wb_dreg <= '0;
			wb_we   <= 1'b0;
		end else begin
			wb_data <= wb_val;
			wb_dreg <= mem_dreg;
			wb_we   <= mem_reg_we;
		end
	end

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

	// primary opcodes that the core decodes
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LB      = 6'h20,
		OP_LH      = 6'h21,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_LHU     = 6'h25,
		OP_SB      = 6'h28,
		OP_SH      = 6'h29,
		OP_SW      = 6'h2b
	} opcode_e;

	// SPECIAL function codes
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

	typedef enum logic [1:0] {MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

	typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_JR} npc_sel_e;

endpackage

/* mips_core.f */
+incdir+hw
hw/mips_pkg.sv
hw/mips_control.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_mem_stage.sv
hw/mips_core.sv
tb/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mips_core \
	-f mips_core.f -o sim_mips_core \
	&& ./obj_dir/sim_mips_core > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }

grep -q "STATUS: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* tb/tb_mips_core.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_mips_core;

	localparam int RESET_CYCLES = 16;
	localparam int FUNC_IDX     = 200; // word index of the jal callee
	localparam int MODEL_STEPS  = 2000;

	logic                  clk;
	logic                  arst_n;
	logic [`MIPS_XLEN-1:0] inst_data;
	logic [`MIPS_XLEN-1:0] mem_data_in;
	logic [`MIPS_XLEN-1:0] inst_addr;
	logic [`MIPS_XLEN-1:0] mem_addr;
	logic [`MIPS_XLEN-1:0] mem_data;
	logic [3:0]            mem_we;
	logic                  mem_rd;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] mmem [0:255]; // model's data memory
	logic [31:0] mreg [0:31];
	logic        touched [0:255];
	logic [31:0] rng;
	int          wr_idx;
	int          st_off;
	int          cycles;
	int          n_got;
	int          n_ld;
	int          err_value;
	int          err_other;
	int          limit;
	int          steps;

	logic [31:0] exp_addr [$];
	logic [3:0]  exp_we [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_ld_addr [$];

	mips_core i_dut (.*);

	assign inst_data   = imem[inst_addr[9:2]];
	assign mem_data_in = dmem[mem_addr[9:2]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	always @(posedge clk) begin
		for (int b = 0; b < 4; b++)
			if (mem_we[b])
				dmem[mem_addr[9:2]][8*b +: 8] <= mem_data[8*b +: 8];
	end

	//////////////////////////////
	// program building
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
	                                       input int sh, input logic [5:0] fn);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
	                                       input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[wr_idx] = w;
		wr_idx++;
	endtask

	task automatic emit_store(input int rt); // sw rt to the next free slot
		emit(enc_i(6'h2b, 20, rt, st_off[15:0]));
		st_off += 4;
	endtask

	task automatic build_program();
		logic [5:0]  r_fn [0:9];
		logic [5:0]  i_op [0:5];
		logic [31:0] r;
		int          sel;
		int          rd;
		r_fn = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02};
		i_op = '{6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0f};
		for (int i = 0; i < 256; i++)
			imem[i] = 32'h0;
		wr_idx = 0;
		st_off = 0;
		for (int k = 1; k <= 8; k++) begin // random constants
			r = next_rand();
			emit(enc_i(6'h0f, 0, k, r[31:16]));
			emit(enc_i(6'h0d, k, k, r[15:0]));
		end
		emit(enc_i(6'h09, 0, 20, 16'h0100)); // store area
		emit(enc_i(6'h09, 0, 21, 16'h0200)); // untouched fill area
		// dependent arithmetic with each result stored at once
		for (int k = 0; k < 16; k++) begin
			r   = next_rand();
			sel = r[3:0];
			rd  = r[6:4] + 1;
			if (sel < 10)
				emit(enc_r(r[9:7] + 1, r[12:10] + 1, rd, r[17:13], r_fn[sel]));
			else
				emit(enc_i(i_op[sel-10], r[9:7] + 1, rd, r[31:16]));
			emit_store(rd);
		end
		// load-use pairs on fill data
		emit(enc_i(6'h23, 21, 9, 16'h0004));
		emit(enc_r(9, 1, 10, 0, 6'h21));
		emit_store(10);
		emit(enc_i(6'h20, 21, 11, 16'h0009));
		emit(enc_r(11, 0, 12, 0, 6'h25));
		emit_store(12);
		emit(enc_i(6'h24, 21, 11, 16'h000e));
		emit_store(11);
		emit(enc_i(6'h21, 21, 11, 16'h0012));
		emit_store(11);
		emit(enc_i(6'h25, 21, 11, 16'h0016));
		emit_store(11);
		// mixed-size stores and their read back
		emit(enc_i(6'h28, 20, 3, 16'h00a1));
		emit(enc_i(6'h28, 20, 4, 16'h00a3));
		emit(enc_i(6'h29, 20, 5, 16'h00a6));
		emit(enc_i(6'h29, 20, 6, 16'h00a8));
		emit(enc_i(6'h20, 20, 13, 16'h00a1));
		emit_store(13);
		emit(enc_i(6'h24, 20, 13, 16'h00a3));
		emit_store(13);
		emit(enc_i(6'h21, 20, 13, 16'h00a6));
		emit_store(13);
		emit(enc_i(6'h25, 20, 13, 16'h00a8));
		emit_store(13);
		// taken beq whose slot runs and whose next word is skipped
		emit(enc_i(6'h04, 1, 1, 16'd2));
		emit(enc_i(6'h09, 0, 14, 16'd7));
		emit(enc_i(6'h2b, 20, 0, 16'h00f0));
		emit_store(14);
		// untaken bne
		emit(enc_i(6'h05, 2, 2, 16'd2));
		emit(enc_i(6'h09, 14, 14, 16'd5));
		emit_store(14);
		// jal/jr round trip
		emit({6'h03, 26'(FUNC_IDX)});
		emit(enc_i(6'h09, 0, 16, 16'd3));
		emit_store(16);
		emit_store(31);
		emit({6'h02, 26'(wr_idx)}); // spin here
		emit(32'h0);
		wr_idx = FUNC_IDX;
		emit(enc_i(6'h09, 0, 15, 16'd9));
		emit(enc_r(31, 0, 0, 0, 6'h08));
		emit_store(15);
	endtask

	//////////////////////////////
	// ISA reference that fills the expected store and load queues
	function automatic int run_model();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nnpc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic [31:0] ea;
		logic [31:0] w;
		logic [31:0] res;
		logic [31:0] sd;
		logic [3:0]  we;
		logic [5:0]  op;
		logic [4:0]  rd;
		logic        wr;
		int          n;
		pc  = `MIPS_RESET_PC;
		npc = pc + 4;
		for (n = 0; n < MODEL_STEPS; n++) begin
			ins  = imem[pc[9:2]];
			op   = ins[31:26];
			a    = mreg[ins[25:21]];
			b    = mreg[ins[20:16]];
			se   = {{16{ins[15]}}, ins[15:0]};
			ze   = {16'h0, ins[15:0]};
			ea   = a + se;
			w    = mmem[ea[9:2]];
			nnpc = npc + 4;
			wr   = 1'b1;
			rd   = ins[20:16];
			res  = 32'h0;
			if (op == 6'h02 && {npc[31:28], ins[25:0], 2'b00} == pc)
				break; // self loop ends the program
			if (op == 6'h20 || op == 6'h21 || op == 6'h23 || op == 6'h24 || op == 6'h25)
				exp_ld_addr.push_back({ea[31:2], 2'b00});
			case (op)
				6'h00: begin
					rd = ins[15:11];
					case (ins[5:0])
						6'h00: res = b << ins[10:6];
						6'h02: res = b >> ins[10:6];
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h27: res = ~(a | b);
						6'h2a: res = {31'h0, $signed(a) < $signed(b)};
						6'h2b: res = {31'h0, a < b};
						6'h08: begin
							nnpc = a;
							wr   = 1'b0;
						end
						default: wr = 1'b0;
					endcase
				end
				6'h02: begin
					nnpc = {npc[31:28], ins[25:0], 2'b00};
					wr   = 1'b0;
				end
				6'h03: begin
					nnpc = {npc[31:28], ins[25:0], 2'b00};
					rd   = `MIPS_LINK_REG;
					res  = pc + 8;
				end
				6'h04, 6'h05: begin
					if ((a == b) == (op == 6'h04))
						nnpc = npc + (se << 2);
					wr = 1'b0;
				end
				6'h09: res = a + se;
				6'h0a: res = {31'h0, $signed(a) < $signed(se)};
				6'h0c: res = a & ze;
				6'h0d: res = a | ze;
				6'h0e: res = a ^ ze;
				6'h0f: res = {ins[15:0], 16'h0};
				6'h20: res = {{24{w[8*ea[1:0]+7]}}, w[8*ea[1:0] +: 8]};
				6'h24: res = {24'h0, w[8*ea[1:0] +: 8]};
				6'h21: res = {{16{w[16*ea[1]+15]}}, w[16*ea[1] +: 16]};
				6'h25: res = {16'h0, w[16*ea[1] +: 16]};
				6'h23: res = w;
				6'h28, 6'h29, 6'h2b: begin
					wr = 1'b0;
					if (op == 6'h28) begin
						we = 4'b0001 << ea[1:0];
						sd = {24'h0, b[7:0]} << (8 * ea[1:0]);
					end else if (op == 6'h29) begin
						we = ea[1] ? 4'b1100 : 4'b0011;
						sd = {16'h0, b[15:0]} << (16 * ea[1]);
					end else begin
						we = 4'b1111;
						sd = b;
					end
					for (int l = 0; l < 4; l++)
						if (we[l])
							mmem[ea[9:2]][8*l +: 8] = sd[8*l +: 8];
					touched[ea[9:2]] = 1'b1;
					exp_addr.push_back({ea[31:2], 2'b00});
					exp_we.push_back(we);
					exp_data.push_back(sd);
				end
				default: wr = 1'b0; // unknown opcode is a nop
			endcase
			if (wr && rd != 0)
				mreg[rd] = res;
			pc  = npc;
			npc = nnpc;
		end
		return n;
	endfunction

	//////////////////////////////
	// checks
	task automatic check_store(input logic [`MIPS_XLEN-1:0] addr, input logic [3:0] we,
	                           input logic [`MIPS_XLEN-1:0] data, input int idx);
		logic [31:0] mask;
		mask = {{8{exp_we[idx][3]}}, {8{exp_we[idx][2]}},
		        {8{exp_we[idx][1]}}, {8{exp_we[idx][0]}}};
		if (addr !== exp_addr[idx] || we !== exp_we[idx] || (data & mask) !== exp_data[idx]) begin
			err_value++;
			$display("Fail %0t: store %0d got %h/%b/%h, expected %h/%b/%h", $time, idx,
			         addr, we, data & mask, exp_addr[idx], exp_we[idx], exp_data[idx]);
		end
	endtask

	task automatic check_load(input logic [`MIPS_XLEN-1:0] addr, input int idx);
		if (addr !== exp_ld_addr[idx]) begin
			err_value++;
			$display("Fail %0t: load %0d read %h, expected %h", $time, idx,
			         addr, exp_ld_addr[idx]);
		end
	endtask

	task automatic check_word(input int idx, input logic [`MIPS_XLEN-1:0] got,
	                          input logic [`MIPS_XLEN-1:0] exp);
		if (got !== exp) begin
			err_value++;
			$display("Fail %0t: memory word %0d is %h, expected %h", $time, idx, got, exp);
		end
	endtask

	// every cycle with a store or a load read is compared in order
	always @(posedge clk) begin
		if (arst_n === 1'b1 && mem_we !== 4'b0000) begin
			if (n_got < exp_addr.size())
				check_store(mem_addr, mem_we, mem_data, n_got);
			else begin
				err_other++;
				$display("extra store to %h at %0t that the model never made", mem_addr, $time);
			end
			n_got++;
		end
		if (arst_n === 1'b1 && mem_rd !== 1'b0) begin
			if (n_ld < exp_ld_addr.size())
				check_load(mem_addr, n_ld);
			else begin
				err_other++;
				$display("extra load from %h at %0t that the model never made", mem_addr, $time);
			end
			n_ld++;
		end
	end

	initial begin
		arst_n    = 1'b0;
		rng       = 32'hb294799e;
		cycles    = 0;
		n_got     = 0;
		n_ld      = 0;
		err_value = 0;
		err_other = 0;
		for (int i = 0; i < 256; i++) begin
			dmem[i]    = {i[15:0] ^ 16'h3c5a, ~i[15:0]} ^ (i * 32'h9e37_79b9); // fill
			mmem[i]    = dmem[i];
			touched[i] = 1'b0;
		end
		for (int i = 0; i < 32; i++)
			mreg[i] = 32'h0;
		build_program();
		steps = run_model();
		limit = 4 * steps + RESET_CYCLES + 50;

		repeat (RESET_CYCLES) @(posedge clk);
		if (inst_addr !== `MIPS_RESET_PC || mem_we !== 4'b0000 || mem_rd !== 1'b0) begin
			err_value++;
			$display("Fail %0t: reset state inst_addr %h mem_we %b mem_rd %b", $time,
			         inst_addr, mem_we, mem_rd);
		end
		#1 arst_n = 1'b1;

		while (n_got < exp_addr.size() && cycles < limit)
			@(posedge clk);
		if (n_got < exp_addr.size()) begin
			err_other++;
			$display("timeout after %0d cycles with %0d of %0d stores seen",
			         cycles, n_got, exp_addr.size());
		end
		repeat (8) @(posedge clk); // catch stray stores
		#1;
		if (n_ld < exp_ld_addr.size()) begin
			err_other++;
			$display("only %0d of %0d loads were read from memory", n_ld, exp_ld_addr.size());
		end
		for (int i = 0; i < 256; i++)
			if (touched[i])
				check_word(i, dmem[i], mmem[i]);

		$display("errors: %0d wrong values, %0d other", err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
